/* design/lce_cfg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// icache coherence engine sizing
// cache geometry, endpoint ids and the width types built on them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package lce_cfg_pkg;

  localparam int LCE_SETS = 16;
  localparam int LCE_ASSOC = 8;
  localparam int PADDR_WIDTH = 40;
  localparam int BLOCK_WIDTH = 512;

  // each directory sends exactly one sync after reset
  localparam int NUM_CCE = 2;

  localparam int LCE_ID_WIDTH = 4;
  localparam int CCE_ID_WIDTH = 4;

  // address split is | tag | index | block offset |
  localparam int BLOCK_OFFSET_WIDTH = 6;
  localparam int INDEX_WIDTH = $clog2(LCE_SETS);
  localparam int WAY_WIDTH = $clog2(LCE_ASSOC);
  localparam int TAG_WIDTH = PADDR_WIDTH - INDEX_WIDTH - BLOCK_OFFSET_WIDTH;

  // shared by the reset sweep and the sync count and must hold LCE_SETS-1
  localparam int CNT_WIDTH = 5;

  typedef logic [PADDR_WIDTH-1:0] paddr_t;
  typedef logic [INDEX_WIDTH-1:0] index_t;
  typedef logic [TAG_WIDTH-1:0] tag_t;
  typedef logic [WAY_WIDTH-1:0] way_t;
  typedef logic [BLOCK_WIDTH-1:0] block_t;
  typedef logic [LCE_ID_WIDTH-1:0] lce_id_t;
  typedef logic [CCE_ID_WIDTH-1:0] cce_id_t;

endpackage

/* design/lce_msg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// icache coherence engine messages
// command and response formats, memory packets and the
// decoded command handed between the command blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package lce_msg_pkg;

  import lce_cfg_pkg::*;

  // commands from the directory
  typedef enum logic [2:0] {
    e_cmd_set_clear,
    e_cmd_sync,
    e_cmd_uc_data,
    e_cmd_set_tag,
    e_cmd_set_tag_wakeup,
    e_cmd_invalidate_tag,
    e_cmd_data,
    e_cmd_writeback
  } lce_cmd_msg_e;

  // responses back to the directory
  typedef enum logic [1:0] {
    e_resp_none,
    e_resp_sync_ack,
    e_resp_inv_ack,
    e_resp_null_wb
  } lce_resp_msg_e;

  typedef enum logic [2:0] {
    e_coh_i,
    e_coh_s,
    e_coh_e,
    e_coh_m
  } coh_state_e;

  typedef enum logic [1:0] {
    e_tag_set_clear,
    e_tag_set_tag,
    e_tag_invalidate
  } tag_op_e;

  typedef enum logic {
    e_data_write,
    e_data_uncached
  } data_op_e;

  typedef struct packed {
    lce_cmd_msg_e msg_type;
    cce_id_t      src_id;
    paddr_t       addr;
    way_t         way_id;
    coh_state_e   state;
    block_t       data;
  } lce_cmd_s;

  typedef struct packed {
    cce_id_t       dst_id;
    lce_id_t       src_id;
    lce_resp_msg_e msg_type;
    paddr_t        addr;
  } lce_resp_s;

  typedef struct packed {
    index_t     index;
    way_t       way_id;
    coh_state_e state;
    tag_t       tag;
    tag_op_e    opcode;
  } tag_mem_pkt_s;

  typedef struct packed {
    index_t   index;
    way_t     way_id;
    block_t   data;
    data_op_e opcode;
  } data_mem_pkt_s;

  // status memory only ever sees a set clear
  typedef struct packed {
    index_t index;
  } stat_mem_pkt_s;

  typedef struct packed {
    index_t        index;
    tag_t          tag;
    way_t          way_id;
    coh_state_e    state;
    logic          uses_tag;
    logic          uses_stat;
    logic          uses_data;
    tag_op_e       tag_op;
    data_op_e      data_op;
    lce_resp_msg_e resp_msg;
    logic          uncached_ok;
  } lce_cmd_dec_s;

endpackage

/* design/lce_cmd_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// icache command decode
// splits the command address and maps each message type to
// the memories, opcodes and response it needs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module lce_cmd_decode (
  input  lce_msg_pkg::lce_cmd_s     cmd_i,
  input  lce_cfg_pkg::paddr_t       miss_addr_i,
  output lce_msg_pkg::lce_cmd_dec_s dec_o
);

  import lce_cfg_pkg::*;
  import lce_msg_pkg::*;

  index_t cmd_index;
  index_t miss_index;
  tag_t   cmd_tag;

  assign cmd_index  = cmd_i.addr[BLOCK_OFFSET_WIDTH +: INDEX_WIDTH];
  assign cmd_tag    = cmd_i.addr[BLOCK_OFFSET_WIDTH + INDEX_WIDTH +: TAG_WIDTH];
  assign miss_index = miss_addr_i[BLOCK_OFFSET_WIDTH +: INDEX_WIDTH];

  always_comb begin
    dec_o          = '0;
    dec_o.index    = cmd_index;
    dec_o.tag      = cmd_tag;
    dec_o.way_id   = cmd_i.way_id;
    dec_o.state    = cmd_i.state;
    dec_o.tag_op   = e_tag_set_clear;
    dec_o.data_op  = e_data_write;
    dec_o.resp_msg = e_resp_none;

    case (cmd_i.msg_type)
      e_cmd_set_clear: begin
        dec_o.uses_tag    = 1'b1;
        dec_o.uses_stat   = 1'b1;
        dec_o.state       = e_coh_i;
        dec_o.tag         = '0;
        dec_o.uncached_ok = 1'b1;
      end
      e_cmd_sync: begin
        dec_o.resp_msg    = e_resp_sync_ack;
        dec_o.uncached_ok = 1'b1;
      end
      // fill data lands in the set that missed
      e_cmd_uc_data: begin
        dec_o.index       = miss_index;
        dec_o.uses_data   = 1'b1;
        dec_o.data_op     = e_data_uncached;
        dec_o.uncached_ok = 1'b1;
      end
      e_cmd_set_tag, e_cmd_set_tag_wakeup: begin
        dec_o.uses_tag = 1'b1;
        dec_o.tag_op   = e_tag_set_tag;
      end
      e_cmd_invalidate_tag: begin
        dec_o.uses_tag = 1'b1;
        dec_o.tag_op   = e_tag_invalidate;
        dec_o.state    = e_coh_i;
        dec_o.tag      = '0;
        dec_o.resp_msg = e_resp_inv_ack;
      end
      e_cmd_data: begin
        dec_o.index     = miss_index;
        dec_o.uses_tag  = 1'b1;
        dec_o.uses_data = 1'b1;
        dec_o.tag_op    = e_tag_set_tag;
        dec_o.data_op   = e_data_write;
      end
      e_cmd_writeback: begin
        dec_o.resp_msg = e_resp_null_wb;
      end
      default: begin
      end
    endcase
  end

endmodule

/* design/lce_cmd_exec.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// icache command execute
// mode FSM with reset sweep and sync counting, memory packet
// issue and command accept for the coherence engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module lce_cmd_exec (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       cmd_v_i,
  input  lce_msg_pkg::lce_cmd_dec_s  dec_i,
  input  lce_cfg_pkg::block_t        data_i,

  input  logic                       tag_ready_i,
  input  logic                       data_ready_i,
  input  logic                       stat_ready_i,
  input  logic                       resp_yumi_i,
  input  logic                       inv_pending_i,

  output logic                       cmd_yumi_o,
  output lce_msg_pkg::tag_mem_pkt_s  tag_pkt_o,
  output logic                       tag_pkt_v_o,
  output lce_msg_pkg::data_mem_pkt_s data_pkt_o,
  output logic                       data_pkt_v_o,
  output lce_msg_pkg::stat_mem_pkt_s stat_pkt_o,
  output logic                       stat_pkt_v_o,

  output logic                       resp_v_o,
  output logic                       tag_fire_o,
  output logic                       ready_mode_o,
  output logic                       lce_ready_o
);

  import lce_cfg_pkg::*;
  import lce_msg_pkg::*;

  typedef enum logic [1:0] {
    e_sweep,
    e_uncached_only,
    e_ready
  } mode_e;

  mode_e state_r;
  mode_e state_n;

  logic [CNT_WIDTH-1:0] cnt_r;
  logic [CNT_WIDTH-1:0] cnt_n;

  logic sweep_go;
  logic last_set;
  logic last_sync;
  logic active;
  logic is_inv;
  logic resp_need;
  logic tag_ok;
  logic stat_ok;
  logic data_ok;
  logic mem_ok;
  logic accept;
  logic sync_acked;

  // sweep only advances when both memories take the clear together
  assign sweep_go  = (state_r == e_sweep) & tag_ready_i & stat_ready_i;
  assign last_set  = (cnt_r == CNT_WIDTH'(LCE_SETS - 1));
  assign last_sync = (cnt_r == CNT_WIDTH'(NUM_CCE - 1));

  // uncached-only mode takes just the commands decode marks as allowed
  assign active = cmd_v_i & (state_r != e_sweep)
                & ((state_r == e_ready) | dec_i.uncached_ok);

  assign is_inv    = dec_i.uses_tag & (dec_i.tag_op == e_tag_invalidate);
  assign resp_need = (dec_i.resp_msg != e_resp_none);

  // a pending invalidate already wrote its tag, so it no longer needs the tag memory
  assign tag_ok  = ~dec_i.uses_tag | tag_ready_i | (is_inv & inv_pending_i);
  assign stat_ok = ~dec_i.uses_stat | stat_ready_i;
  assign data_ok = ~dec_i.uses_data | data_ready_i;
  assign mem_ok  = tag_ok & stat_ok & data_ok;

  assign accept     = active & mem_ok & (~resp_need | resp_yumi_i);
  assign cmd_yumi_o = accept;
  assign resp_v_o   = active & mem_ok & resp_need;

  assign sync_acked = accept & (dec_i.resp_msg == e_resp_sync_ack);

  always_comb begin
    tag_pkt_o        = '0;
    tag_pkt_o.index  = dec_i.index;
    tag_pkt_o.way_id = dec_i.way_id;
    tag_pkt_o.state  = dec_i.state;
    tag_pkt_o.tag    = dec_i.tag;
    tag_pkt_o.opcode = dec_i.tag_op;

    data_pkt_o.index  = dec_i.index;
    data_pkt_o.way_id = dec_i.way_id;
    data_pkt_o.data   = data_i;
    data_pkt_o.opcode = dec_i.data_op;

    stat_pkt_o.index = dec_i.index;

    if (state_r == e_sweep) begin
      tag_pkt_o.index  = cnt_r[INDEX_WIDTH-1:0];
      tag_pkt_o.way_id = '0;
      tag_pkt_o.state  = e_coh_i;
      tag_pkt_o.tag    = '0;
      tag_pkt_o.opcode = e_tag_set_clear;
      stat_pkt_o.index = cnt_r[INDEX_WIDTH-1:0];

      tag_pkt_v_o  = sweep_go;
      stat_pkt_v_o = sweep_go;
      data_pkt_v_o = 1'b0;
    end else begin
      // invalidate writes its tag ahead of the ack and only once
      if (is_inv) begin
        tag_pkt_v_o = active & tag_ready_i & ~inv_pending_i;
      end else begin
        tag_pkt_v_o = dec_i.uses_tag & accept;
      end
      stat_pkt_v_o = dec_i.uses_stat & accept;
      data_pkt_v_o = dec_i.uses_data & accept;
    end
  end

  assign tag_fire_o = tag_pkt_v_o;

  always_comb begin
    state_n = state_r;
    cnt_n   = cnt_r;

    case (state_r)
      e_sweep: begin
        if (sweep_go) begin
          if (last_set) begin
            state_n = e_uncached_only;
            cnt_n   = '0;
          end else begin
            cnt_n = cnt_r + 1'b1;
          end
        end
      end
      e_uncached_only: begin
        if (sync_acked) begin
          if (last_sync) begin
            state_n = e_ready;
            cnt_n   = '0;
          end else begin
            cnt_n = cnt_r + 1'b1;
          end
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_sweep;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      cnt_r   <= cnt_n;
    end
  end

  assign ready_mode_o = (state_r == e_ready);
  assign lce_ready_o  = (state_r != e_sweep);

endmodule

/* design/lce_resp_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// icache response unit
// packs responses, tracks a pending invalidate ack and raises
// the strobes seen by the miss logic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module lce_resp_unit (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  lce_cfg_pkg::lce_id_t      lce_id_i,
  input  lce_msg_pkg::lce_cmd_s     cmd_i,
  input  lce_msg_pkg::lce_cmd_dec_s dec_i,
  input  logic                      resp_v_i,
  input  logic                      tag_fire_i,
  input  logic                      cmd_yumi_i,
  input  logic                      resp_yumi_i,
  input  logic                      ready_mode_i,

  output lce_msg_pkg::lce_resp_s    resp_o,
  output logic                      resp_v_o,
  output logic                      inv_pending_o,

  output logic                      set_tag_received_o,
  output logic                      set_tag_wakeup_received_o,
  output logic                      cce_data_received_o,
  output logic                      uncached_data_received_o,
  output logic                      cache_req_complete_o
);

  import lce_msg_pkg::*;

  logic inv_ack;
  logic inv_pending_r;
  logic inv_pending_n;
  logic ready_fire;
  logic is_set_tag;
  logic is_wakeup;
  logic is_data;
  logic is_uc_data;

  assign inv_ack = (dec_i.resp_msg == e_resp_inv_ack);

  always_comb begin
    resp_o          = '0;
    resp_o.dst_id   = cmd_i.src_id;
    resp_o.src_id   = lce_id_i;
    resp_o.msg_type = dec_i.resp_msg;
    // sync acks carry no address
    if (inv_ack | (dec_i.resp_msg == e_resp_null_wb)) begin
      resp_o.addr = cmd_i.addr;
    end
  end

  assign resp_v_o = resp_v_i;

  // tag already invalidated while the ack still waits for the sink
  always_comb begin
    inv_pending_n = inv_pending_r;
    if (inv_ack & resp_yumi_i) begin
      inv_pending_n = 1'b0;
    end else if (inv_ack & tag_fire_i & ready_mode_i) begin
      inv_pending_n = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      inv_pending_r <= 1'b0;
    end else begin
      inv_pending_r <= inv_pending_n;
    end
  end

  assign inv_pending_o = inv_pending_r;

  assign ready_fire = cmd_yumi_i & ready_mode_i;
  assign is_set_tag = (cmd_i.msg_type == e_cmd_set_tag);
  assign is_wakeup  = (cmd_i.msg_type == e_cmd_set_tag_wakeup);
  assign is_data    = (cmd_i.msg_type == e_cmd_data);
  assign is_uc_data = (cmd_i.msg_type == e_cmd_uc_data);

  assign set_tag_received_o        = ready_fire & (is_set_tag | is_data);
  assign set_tag_wakeup_received_o = ready_fire & is_wakeup;
  assign cce_data_received_o       = ready_fire & is_data;
  assign uncached_data_received_o  = cmd_yumi_i & is_uc_data;
  assign cache_req_complete_o      = (ready_fire & (is_wakeup | is_data))
                                   | (cmd_yumi_i & is_uc_data);

endmodule

/* design/lce_cmd_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// icache coherence command handler
// decode, execute and response blocks of the cache engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module lce_cmd_top (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  lce_cfg_pkg::lce_id_t       lce_id_i,
  input  lce_cfg_pkg::paddr_t        miss_addr_i,

  input  lce_msg_pkg::lce_cmd_s      lce_cmd_i,
  input  logic                       lce_cmd_v_i,
  output logic                       lce_cmd_yumi_o,

  output lce_msg_pkg::lce_resp_s     lce_resp_o,
  output logic                       lce_resp_v_o,
  input  logic                       lce_resp_yumi_i,

  output lce_msg_pkg::tag_mem_pkt_s  tag_mem_pkt_o,
  output logic                       tag_mem_pkt_v_o,
  input  logic                       tag_mem_pkt_ready_i,
  output lce_msg_pkg::data_mem_pkt_s data_mem_pkt_o,
  output logic                       data_mem_pkt_v_o,
  input  logic                       data_mem_pkt_ready_i,
  output lce_msg_pkg::stat_mem_pkt_s stat_mem_pkt_o,
  output logic                       stat_mem_pkt_v_o,
  input  logic                       stat_mem_pkt_ready_i,

  output logic                       lce_ready_o,
  output logic                       set_tag_received_o,
  output logic                       set_tag_wakeup_received_o,
  output logic                       cce_data_received_o,
  output logic                       uncached_data_received_o,
  output logic                       cache_req_complete_o
);

  import lce_msg_pkg::*;

  lce_cmd_dec_s dec;
  logic         resp_v;
  logic         tag_fire;
  logic         ready_mode;
  logic         inv_pending;

  lce_cmd_decode decode0 (
    .cmd_i       (lce_cmd_i),
    .miss_addr_i (miss_addr_i),
    .dec_o       (dec)
  );

  lce_cmd_exec exec0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cmd_v_i       (lce_cmd_v_i),
    .dec_i         (dec),
    .data_i        (lce_cmd_i.data),
    .tag_ready_i   (tag_mem_pkt_ready_i),
    .data_ready_i  (data_mem_pkt_ready_i),
    .stat_ready_i  (stat_mem_pkt_ready_i),
    .resp_yumi_i   (lce_resp_yumi_i),
    .inv_pending_i (inv_pending),
    .cmd_yumi_o    (lce_cmd_yumi_o),
    .tag_pkt_o     (tag_mem_pkt_o),
    .tag_pkt_v_o   (tag_mem_pkt_v_o),
    .data_pkt_o    (data_mem_pkt_o),
    .data_pkt_v_o  (data_mem_pkt_v_o),
    .stat_pkt_o    (stat_mem_pkt_o),
    .stat_pkt_v_o  (stat_mem_pkt_v_o),
    .resp_v_o      (resp_v),
    .tag_fire_o    (tag_fire),
    .ready_mode_o  (ready_mode),
    .lce_ready_o   (lce_ready_o)
  );

  lce_resp_unit resp0 (
    .clk_i                     (clk_i),
    .reset_i                   (reset_i),
    .lce_id_i                  (lce_id_i),
    .cmd_i                     (lce_cmd_i),
    .dec_i                     (dec),
    .resp_v_i                  (resp_v),
    .tag_fire_i                (tag_fire),
    .cmd_yumi_i                (lce_cmd_yumi_o),
    .resp_yumi_i               (lce_resp_yumi_i),
    .ready_mode_i              (ready_mode),
    .resp_o                    (lce_resp_o),
    .resp_v_o                  (lce_resp_v_o),
    .inv_pending_o             (inv_pending),
    .set_tag_received_o        (set_tag_received_o),
    .set_tag_wakeup_received_o (set_tag_wakeup_received_o),
    .cce_data_received_o       (cce_data_received_o),
    .uncached_data_received_o  (uncached_data_received_o),
    .cache_req_complete_o      (cache_req_complete_o)
  );

endmodule

/* include/tb_lce_cmd_tasks.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// icache coherence command handler test tasks
// checks, random stimulus, wait helpers and directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_LCE_CMD_TASKS_SVH
`define TB_LCE_CMD_TASKS_SVH

task automatic abort_run(input string msg);
  $display("%s", msg);
  $display("test failed");
  $fatal(1, "simulation stopped on first error");
endtask

task automatic check_eq(input string test, input logic [BLOCK_WIDTH-1:0] expected,
                        input logic [BLOCK_WIDTH-1:0] actual);
  if (expected !== actual) begin
    abort_run($sformatf("FAILED %s expected %0h actual %0h", test, expected, actual));
  end
endtask

// galois form with taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic [31:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 32'h80200003;
  end
  return n;
endfunction

task automatic rand_bits(input int n, output logic [BLOCK_WIDTH-1:0] v);
  v = '0;
  for (int i = 0; i < n; i++) begin
    v[i]   = lfsr_r[0];
    lfsr_r = lfsr_next(lfsr_r);
  end
endtask

task automatic rand_cmd(input lce_cmd_msg_e msg, output lce_cmd_s c);
  logic [BLOCK_WIDTH-1:0] r;
  c = '0;
  c.msg_type = msg;
  rand_bits(CCE_ID_WIDTH, r);
  c.src_id = r[CCE_ID_WIDTH-1:0];
  rand_bits(PADDR_WIDTH, r);
  c.addr = r[PADDR_WIDTH-1:0];
  rand_bits(WAY_WIDTH, r);
  c.way_id = r[WAY_WIDTH-1:0];
  rand_bits(2, r);
  case (r[1:0])
    2'd0: c.state = e_coh_s;
    2'd1: c.state = e_coh_e;
    default: c.state = e_coh_m;
  endcase
  rand_bits(BLOCK_WIDTH, r);
  c.data = r;
endtask

task automatic rand_miss_addr();
  logic [BLOCK_WIDTH-1:0] r;
  rand_bits(PADDR_WIDTH, r);
  miss_addr = r[PADDR_WIDTH-1:0];
endtask

// address layout is | tag | index | 6 bit block offset |
function automatic index_t index_of(input paddr_t a);
  return a[BLOCK_OFFSET_WIDTH +: INDEX_WIDTH];
endfunction

function automatic tag_t tag_of(input paddr_t a);
  return a[PADDR_WIDTH-1 -: TAG_WIDTH];
endfunction

task automatic next_drive();
  @(posedge clk);
  #2;
endtask

// returns at the falling edge of the accepting cycle
task automatic wait_accept(input string test);
  int n;
  n = 0;
  @(negedge clk);
  while (!cmd_yumi) begin
    n++;
    if (n > WAIT_LIMIT) begin
      abort_run($sformatf("%s: command was never accepted", test));
    end
    @(negedge clk);
  end
endtask

// order is set_tag, wakeup, cce_data, uncached_data, complete
task automatic check_strobes(input string test, input logic [4:0] expected);
  check_eq({test, " strobes"}, expected, {set_tag_rcv, wakeup_rcv, data_rcv, uc_rcv, complete});
endtask

task automatic check_tag_pkt(input string test, input index_t idx, input tag_t tag,
                             input way_t way, input coh_state_e st, input tag_op_e op);
  check_eq({test, " tag valid"}, 1, tag_v);
  check_eq({test, " tag index"}, idx, tag_pkt.index);
  check_eq({test, " tag value"}, tag, tag_pkt.tag);
  check_eq({test, " tag way"}, way, tag_pkt.way_id);
  check_eq({test, " tag state"}, st, tag_pkt.state);
  check_eq({test, " tag opcode"}, op, tag_pkt.opcode);
endtask

task automatic check_data_pkt(input string test, input index_t idx, input lce_cmd_s c,
                              input data_op_e op);
  check_eq({test, " data valid"}, 1, data_v);
  check_eq({test, " data index"}, idx, data_pkt.index);
  check_eq({test, " data way"}, c.way_id, data_pkt.way_id);
  check_eq({test, " data block"}, c.data, data_pkt.data);
  check_eq({test, " data opcode"}, op, data_pkt.opcode);
endtask

task automatic check_resp(input string test, input lce_cmd_s c, input lce_resp_msg_e msg,
                          input paddr_t addr);
  check_eq({test, " resp valid"}, 1, resp_v);
  check_eq({test, " resp type"}, msg, resp.msg_type);
  check_eq({test, " resp dst"}, c.src_id, resp.dst_id);
  check_eq({test, " resp src"}, lce_id, resp.src_id);
  check_eq({test, " resp addr"}, addr, resp.addr);
endtask

task automatic test_reset_sweep();
  int tag_cnt;
  int stat_cnt;
  int n;
  tag_cnt  = 0;
  stat_cnt = 0;
  n        = 0;
  @(negedge clk);
  while (!lce_ready) begin
    if (tag_v) begin
      check_eq("reset_sweep tag index", tag_cnt, tag_pkt.index);
      check_eq("reset_sweep tag state", e_coh_i, tag_pkt.state);
      check_eq("reset_sweep tag opcode", e_tag_set_clear, tag_pkt.opcode);
      tag_cnt++;
    end
    if (stat_v) begin
      check_eq("reset_sweep stat index", stat_cnt, stat_pkt.index);
      stat_cnt++;
    end
    n++;
    if (n > WAIT_LIMIT) begin
      abort_run("reset_sweep: lce_ready never rose after reset");
    end
    @(negedge clk);
  end
  check_eq("reset_sweep tag count", LCE_SETS, tag_cnt);
  check_eq("reset_sweep stat count", LCE_SETS, stat_cnt);
  check_eq("reset_sweep cycles", LCE_SETS, n);
endtask

task automatic test_uncached_mode();
  lce_cmd_s c;
  next_drive();
  rand_cmd(e_cmd_set_tag, c);
  cmd   = c;
  cmd_v = 1'b1;
  // tag commands have to wait for the syncs
  repeat (20) begin
    @(negedge clk);
    check_eq("uncached set_tag yumi", 0, cmd_yumi);
    check_eq("uncached set_tag tag valid", 0, tag_v);
  end
  next_drive();
  rand_miss_addr();
  rand_cmd(e_cmd_uc_data, c);
  cmd = c;
  wait_accept("uncached uc_data");
  check_data_pkt("uncached uc_data", index_of(miss_addr), c, e_data_uncached);
  check_strobes("uncached uc_data", 5'b00011);
  for (int i = 0; i < NUM_CCE; i++) begin
    next_drive();
    rand_cmd(e_cmd_sync, c);
    cmd = c;
    wait_accept("uncached sync");
    check_resp("uncached sync", c, e_resp_sync_ack, '0);
  end
  next_drive();
  cmd_v = 1'b0;
endtask

task automatic test_tag_cmds();
  lce_cmd_s c;
  next_drive();
  rand_cmd(e_cmd_set_tag, c);
  cmd   = c;
  cmd_v = 1'b1;
  wait_accept("set_tag");
  check_tag_pkt("set_tag", index_of(c.addr), tag_of(c.addr), c.way_id, c.state,
                e_tag_set_tag);
  check_strobes("set_tag", 5'b10000);
  next_drive();
  rand_cmd(e_cmd_set_tag_wakeup, c);
  cmd = c;
  wait_accept("set_tag_wakeup");
  check_tag_pkt("set_tag_wakeup", index_of(c.addr), tag_of(c.addr), c.way_id, c.state,
                e_tag_set_tag);
  check_strobes("set_tag_wakeup", 5'b01001);
  next_drive();
  rand_miss_addr();
  rand_cmd(e_cmd_data, c);
  cmd = c;
  wait_accept("data");
  check_tag_pkt("data", index_of(miss_addr), tag_of(c.addr), c.way_id, c.state,
                e_tag_set_tag);
  check_data_pkt("data", index_of(miss_addr), c, e_data_write);
  check_strobes("data", 5'b10101);
  next_drive();
  cmd_v = 1'b0;
endtask

task automatic test_invalidate_backpressure();
  lce_cmd_s c;
  int       tag_cnt;
  tag_cnt = 0;
  next_drive();
  resp_yumi = 1'b0;
  rand_cmd(e_cmd_invalidate_tag, c);
  cmd   = c;
  cmd_v = 1'b1;
  repeat (6) begin
    @(negedge clk);
    if (tag_v) begin
      check_tag_pkt("invalidate", index_of(c.addr), '0, c.way_id, e_coh_i, e_tag_invalidate);
      tag_cnt++;
    end
    check_eq("invalidate held yumi", 0, cmd_yumi);
    check_resp("invalidate held", c, e_resp_inv_ack, c.addr);
  end
  check_eq("invalidate tag count", 1, tag_cnt);
  next_drive();
  resp_yumi = 1'b1;
  wait_accept("invalidate release");
  check_eq("invalidate release tag valid", 0, tag_v);
  check_resp("invalidate release", c, e_resp_inv_ack, c.addr);
  next_drive();
  cmd_v = 1'b0;
endtask

task automatic test_mem_backpressure();
  lce_cmd_s c;
  next_drive();
  data_ready = 1'b0;
  rand_miss_addr();
  rand_cmd(e_cmd_data, c);
  cmd   = c;
  cmd_v = 1'b1;
  repeat (8) begin
    @(negedge clk);
    check_eq("mem_bp held yumi", 0, cmd_yumi);
    check_eq("mem_bp held tag valid", 0, tag_v);
    check_eq("mem_bp held data valid", 0, data_v);
    check_strobes("mem_bp held", 5'b00000);
  end
  next_drive();
  data_ready = 1'b1;
  wait_accept("mem_bp data");
  check_tag_pkt("mem_bp data", index_of(miss_addr), tag_of(c.addr), c.way_id, c.state,
                e_tag_set_tag);
  check_data_pkt("mem_bp data", index_of(miss_addr), c, e_data_write);
  check_strobes("mem_bp data", 5'b10101);
  next_drive();
  rand_cmd(e_cmd_writeback, c);
  cmd   = c;
  cmd_v = 1'b1;
  wait_accept("writeback");
  check_resp("writeback", c, e_resp_null_wb, c.addr);
  check_eq("writeback tag valid", 0, tag_v);
  check_eq("writeback data valid", 0, data_v);
  check_eq("writeback stat valid", 0, stat_v);
  next_drive();
  cmd_v = 1'b0;
endtask

`endif

/* tb/tb_lce_cmd.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// icache coherence command handler testbench
// clock, reset, memory readies and the directed test sequence
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_lce_cmd;

  import lce_cfg_pkg::*;
  import lce_msg_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int WAIT_LIMIT = 200;

  logic          clk = 1'b0;
  logic          reset;
  lce_id_t       lce_id;
  paddr_t        miss_addr;

  lce_cmd_s      cmd;
  logic          cmd_v;
  logic          cmd_yumi;
  lce_resp_s     resp;
  logic          resp_v;
  logic          resp_yumi;

  tag_mem_pkt_s  tag_pkt;
  logic          tag_v;
  logic          tag_ready;
  data_mem_pkt_s data_pkt;
  logic          data_v;
  logic          data_ready;
  stat_mem_pkt_s stat_pkt;
  logic          stat_v;
  logic          stat_ready;

  logic          lce_ready;
  logic          set_tag_rcv;
  logic          wakeup_rcv;
  logic          data_rcv;
  logic          uc_rcv;
  logic          complete;

  logic [31:0]   lfsr_r;

  always #10 clk = ~clk;

  lce_cmd_top dut0 (
    .clk_i                     (clk),
    .reset_i                   (reset),
    .lce_id_i                  (lce_id),
    .miss_addr_i               (miss_addr),
    .lce_cmd_i                 (cmd),
    .lce_cmd_v_i               (cmd_v),
    .lce_cmd_yumi_o            (cmd_yumi),
    .lce_resp_o                (resp),
    .lce_resp_v_o              (resp_v),
    .lce_resp_yumi_i           (resp_yumi),
    .tag_mem_pkt_o             (tag_pkt),
    .tag_mem_pkt_v_o           (tag_v),
    .tag_mem_pkt_ready_i       (tag_ready),
    .data_mem_pkt_o            (data_pkt),
    .data_mem_pkt_v_o          (data_v),
    .data_mem_pkt_ready_i      (data_ready),
    .stat_mem_pkt_o            (stat_pkt),
    .stat_mem_pkt_v_o          (stat_v),
    .stat_mem_pkt_ready_i      (stat_ready),
    .lce_ready_o               (lce_ready),
    .set_tag_received_o        (set_tag_rcv),
    .set_tag_wakeup_received_o (wakeup_rcv),
    .cce_data_received_o       (data_rcv),
    .uncached_data_received_o  (uc_rcv),
    .cache_req_complete_o      (complete)
  );

  `include "tb_lce_cmd_tasks.svh"

  initial begin
    reset     = 1'b1;
    lce_id    = 4'h5;
    miss_addr = '0;
    cmd       = '0;
    cmd_v     = 1'b0;
    // response sink always takes unless a test holds it off
    resp_yumi = 1'b1;
    // memories ready unless a test lowers them
    tag_ready  = 1'b1;
    data_ready = 1'b1;
    stat_ready = 1'b1;
    lfsr_r     = 32'h1c7aa331;

    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset = 1'b0;

    test_reset_sweep();
    test_uncached_mode();
    test_tag_cmds();
    test_invalidate_backpressure();
    test_mem_backpressure();

    $display("test passed");
    $finish;
  end

endmodule

/* tb.f */
+incdir+include
design/lce_cfg_pkg.sv
design/lce_msg_pkg.sv
design/lce_cmd_decode.sv
design/lce_cmd_exec.sv
design/lce_resp_unit.sv
design/lce_cmd_top.sv
tb/tb_lce_cmd.sv

/* Bender.yml */
package:
  name: lce_cmd

sources:
  - design/lce_cfg_pkg.sv
  - design/lce_msg_pkg.sv
  - design/lce_cmd_decode.sv
  - design/lce_cmd_exec.sv
  - design/lce_resp_unit.sv
  - design/lce_cmd_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_lce_cmd.sv
